//--- logic/vid_defines.svh
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// ==================================================
// cpu address map
// ==================================================

`define VID_PAT_START    16'hc000  // tile pattern window base
`define VID_PAT_WORDS    1024      // 16 tiles of 64 pixels

`define VID_FB_START     16'he000  // framebuffer window base
`define VID_FB_WORDS     512       // two tile indices per word

`define VID_SCALE_REG    16'hfffc
`define VID_HSCROLL_REG  16'hfffd
`define VID_VSCROLL_REG  16'hfffe

// ==================================================
// tile geometry
// ==================================================

`define VID_MAP_COLS     32        // tiles per framebuffer row
`define VID_TILE_PIX     8         // pixels per tile edge
`define VID_TILE_COUNT   16        // tiles held in pattern memory

`endif

//--- logic/vid_pkg.sv
`default_nettype none

package vid_pkg;

    typedef logic [15:0] addr_t;      // cpu bus address
    typedef logic [15:0] word_t;      // cpu data / memory word

    typedef logic [9:0]  coord_t;     // screen or scrolled coordinate
    typedef logic [1:0]  scale_t;     // right shift applied to screen coords

    typedef logic [7:0]  tile_idx_t;  // one framebuffer byte

    // 4 bits each of red, green and blue
    typedef logic [11:0] pixel_t;

endpackage

`default_nettype wire

//--- logic/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter  int DEPTH = 512,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic           clk,
    input  logic           we,
    input  logic [AW-1:0]  waddr,
    input  vid_pkg::word_t wdata,
    input  logic [AW-1:0]  cpu_raddr,
    output vid_pkg::word_t cpu_rdata,
    input  logic [AW-1:0]  disp_raddr,
    output vid_pkg::word_t disp_rdata
);

    vid_pkg::word_t mem [DEPTH];

    // both read ports see the contents from before this edge's write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        cpu_rdata  <= mem[cpu_raddr];  // cpu side, 1 cycle
        disp_rdata <= mem[disp_raddr]; // display side, 1 cycle
    end

    a_waddr_in_range: assert property (
        @(posedge clk) we |-> (waddr < DEPTH)
    );

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defines.svh"

module bus_decoder (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                wen,
    input  vid_pkg::addr_t                      waddr,
    input  vid_pkg::word_t                      wdata,
    input  vid_pkg::addr_t                      raddr,
    output logic                                fb_we,
    output logic                                pat_we,
    output logic [$clog2(`VID_PAT_WORDS)-1:0]   ram_waddr,
    output logic [$clog2(`VID_PAT_WORDS)-1:0]   ram_raddr,
    input  vid_pkg::word_t                      fb_cpu_rdata,
    input  vid_pkg::word_t                      pat_cpu_rdata,
    output vid_pkg::word_t                      rdata,
    output vid_pkg::scale_t                     scale,
    output vid_pkg::coord_t                     hscroll,
    output vid_pkg::coord_t                     vscroll
);

    localparam int OFS_W = $clog2(`VID_PAT_WORDS); // wide enough for either region

    logic           rd_fb_q;
    logic           rd_pat_q;
    logic           rd_reg_q;
    logic           reg_hit;
    vid_pkg::word_t reg_word;
    vid_pkg::word_t reg_word_q;
    vid_pkg::word_t next_rdata;

    function automatic logic is_fb(input vid_pkg::addr_t a);
        return (a >= `VID_FB_START) && (a < (`VID_FB_START + `VID_FB_WORDS));
    endfunction

    function automatic logic is_pat(input vid_pkg::addr_t a);
        return (a >= `VID_PAT_START) && (a < (`VID_PAT_START + `VID_PAT_WORDS));
    endfunction

    function automatic logic [OFS_W-1:0] region_offset(input vid_pkg::addr_t a);
        vid_pkg::addr_t base;
        base = is_fb(a) ? vid_pkg::addr_t'(`VID_FB_START) : vid_pkg::addr_t'(`VID_PAT_START);
        return OFS_W'(a - base);
    endfunction

    // ==================================================
    // write decode
    // ==================================================

    assign fb_we     = wen && is_fb(waddr);
    assign pat_we    = wen && is_pat(waddr);
    assign ram_waddr = region_offset(waddr);
    assign ram_raddr = region_offset(raddr); // unmapped reads are zeroed later

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scale   <= '0;
            hscroll <= '0;
            vscroll <= '0;
        end else if (wen) begin
            case (waddr)
                `VID_SCALE_REG:   scale   <= wdata[1:0];
                `VID_HSCROLL_REG: hscroll <= wdata[9:0];
                `VID_VSCROLL_REG: vscroll <= wdata[9:0];
                default: ;
            endcase
        end
    end

    // ==================================================
    // read path
    // ==================================================

    // Register values are captured on the same edge the RAMs sample their
    // address, so a read colliding with a register write sees the old value.
    always_comb begin
        reg_hit  = 1'b1;
        reg_word = '0;
        case (raddr)
            `VID_SCALE_REG:   reg_word = vid_pkg::word_t'(scale);
            `VID_HSCROLL_REG: reg_word = vid_pkg::word_t'(hscroll);
            `VID_VSCROLL_REG: reg_word = vid_pkg::word_t'(vscroll);
            default:          reg_hit  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_word_q <= reg_word;
    end

    always_comb begin
        if (rd_fb_q) begin
            next_rdata = fb_cpu_rdata;
        end else if (rd_pat_q) begin
            next_rdata = pat_cpu_rdata;
        end else if (rd_reg_q) begin
            next_rdata = reg_word_q;
        end else begin
            next_rdata = '0; // unmapped
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_fb_q  <= 1'b0;
            rd_pat_q <= 1'b0;
            rd_reg_q <= 1'b0;
            rdata    <= '0;
        end else begin
            rd_fb_q  <= is_fb(raddr);
            rd_pat_q <= is_pat(raddr);
            rd_reg_q <= reg_hit;
            rdata    <= next_rdata; // second cycle of read latency
        end
    end

    a_one_region_write: assert property (
        @(posedge clk) disable iff (!arst_n) !(fb_we && pat_we)
    );

endmodule

`default_nettype wire

//--- logic/tile_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defines.svh"

module tile_renderer (
    input  logic                               clk,
    input  logic                               arst_n,
    input  vid_pkg::coord_t                    pixel_x,
    input  vid_pkg::coord_t                    pixel_y,
    input  vid_pkg::scale_t                    scale,
    input  vid_pkg::coord_t                    hscroll,
    input  vid_pkg::coord_t                    vscroll,
    output logic [$clog2(`VID_FB_WORDS)-1:0]   fb_rd_addr,
    input  vid_pkg::word_t                     fb_rd_data,
    output logic [$clog2(`VID_PAT_WORDS)-1:0]  pat_rd_addr,
    input  vid_pkg::word_t                     pat_rd_data,
    output vid_pkg::pixel_t                    pixel
);

    localparam int TILE_SHIFT = $clog2(`VID_TILE_PIX);
    localparam int COL_BITS   = $clog2(`VID_MAP_COLS);
    localparam int ROW_BITS   = $clog2(`VID_FB_WORDS * 2 / `VID_MAP_COLS);
    localparam int TILE_BITS  = $clog2(`VID_TILE_COUNT);

    vid_pkg::coord_t              sx;
    vid_pkg::coord_t              sy;
    logic [ROW_BITS+COL_BITS-1:0] slot;
    logic                         odd_q;
    logic [TILE_SHIFT-1:0]        fine_x_q;
    logic [TILE_SHIFT-1:0]        fine_y_q;
    vid_pkg::tile_idx_t           tile;
    logic [1:0]                   live_q;

    // ==================================================
    // stage 1: coordinate to framebuffer word
    // ==================================================

    assign sx   = (pixel_x >> scale) + hscroll; // wraps at 1024
    assign sy   = (pixel_y >> scale) + vscroll;
    assign slot = {sy[TILE_SHIFT +: ROW_BITS], sx[TILE_SHIFT +: COL_BITS]};

    assign fb_rd_addr = slot[ROW_BITS+COL_BITS-1:1]; // two slots per word

    always_ff @(posedge clk) begin
        odd_q    <= slot[0];
        fine_x_q <= sx[TILE_SHIFT-1:0];
        fine_y_q <= sy[TILE_SHIFT-1:0];
    end

    // ==================================================
    // stage 2: tile byte to pattern word
    // ==================================================

    assign tile        = odd_q ? fb_rd_data[15:8] : fb_rd_data[7:0];
    assign pat_rd_addr = {tile[TILE_BITS-1:0], fine_y_q, fine_x_q}; // tile mod 16

    // tracks how far valid coordinates have travelled since reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live_q <= '0;
        end else begin
            live_q <= {live_q[0], 1'b1};
        end
    end

    // the pattern RAM output register holds the colour
    assign pixel = live_q[1] ? vid_pkg::pixel_t'(pat_rd_data[11:0]) : '0;

    a_pixel_known: assert property (
        @(posedge clk) disable iff (!arst_n) live_q[1] |-> !$isunknown(pixel)
    );

endmodule

`default_nettype wire

//--- logic/vid_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defines.svh"

module vid_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wen,
    input  vid_pkg::addr_t  waddr,
    input  vid_pkg::word_t  wdata,
    input  vid_pkg::addr_t  raddr,
    output vid_pkg::word_t  rdata,
    input  vid_pkg::coord_t pixel_x,
    input  vid_pkg::coord_t pixel_y,
    output vid_pkg::pixel_t pixel
);

    localparam int FB_AW  = $clog2(`VID_FB_WORDS);
    localparam int PAT_AW = $clog2(`VID_PAT_WORDS);

    logic              fb_we;
    logic              pat_we;
    logic [PAT_AW-1:0] ram_waddr;
    logic [PAT_AW-1:0] ram_raddr;
    vid_pkg::word_t    fb_cpu_rdata;
    vid_pkg::word_t    pat_cpu_rdata;
    vid_pkg::scale_t   scale;
    vid_pkg::coord_t   hscroll;
    vid_pkg::coord_t   vscroll;
    logic [FB_AW-1:0]  fb_rd_addr;
    vid_pkg::word_t    fb_rd_data;
    logic [PAT_AW-1:0] pat_rd_addr;
    vid_pkg::word_t    pat_rd_data;

    // ==================================================
    // cpu side
    // ==================================================

    bus_decoder u_bus_decoder (
        .clk           (clk),
        .arst_n        (arst_n),
        .wen           (wen),
        .waddr         (waddr),
        .wdata         (wdata),
        .raddr         (raddr),
        .fb_we         (fb_we),
        .pat_we        (pat_we),
        .ram_waddr     (ram_waddr),
        .ram_raddr     (ram_raddr),
        .fb_cpu_rdata  (fb_cpu_rdata),
        .pat_cpu_rdata (pat_cpu_rdata),
        .rdata         (rdata),
        .scale         (scale),
        .hscroll       (hscroll),
        .vscroll       (vscroll)
    );

    word_ram #(.DEPTH(`VID_FB_WORDS)) u_fb_ram (
        .clk        (clk),
        .we         (fb_we),
        .waddr      (ram_waddr[FB_AW-1:0]),   // framebuffer is the smaller region
        .wdata      (wdata),
        .cpu_raddr  (ram_raddr[FB_AW-1:0]),
        .cpu_rdata  (fb_cpu_rdata),
        .disp_raddr (fb_rd_addr),
        .disp_rdata (fb_rd_data)
    );

    word_ram #(.DEPTH(`VID_PAT_WORDS)) u_pat_ram (
        .clk        (clk),
        .we         (pat_we),
        .waddr      (ram_waddr),
        .wdata      (wdata),
        .cpu_raddr  (ram_raddr),
        .cpu_rdata  (pat_cpu_rdata),
        .disp_raddr (pat_rd_addr),
        .disp_rdata (pat_rd_data)
    );

    // ==================================================
    // display side
    // ==================================================

    tile_renderer u_tile_renderer (
        .clk         (clk),
        .arst_n      (arst_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .scale       (scale),
        .hscroll     (hscroll),
        .vscroll     (vscroll),
        .fb_rd_addr  (fb_rd_addr),
        .fb_rd_data  (fb_rd_data),
        .pat_rd_addr (pat_rd_addr),
        .pat_rd_data (pat_rd_data),
        .pixel       (pixel)
    );

endmodule

`default_nettype wire

//--- dv/tb_vid_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defines.svh"

module tb_vid_top;

    localparam int         CLK_PERIOD   = 4;
    localparam int         RESET_CYCLES = 10;
    localparam int         NUM_TESTS    = 6;
    localparam logic [1:0] OP_WRITE     = 2'd0;
    localparam logic [1:0] OP_READ      = 2'd1;
    localparam logic [1:0] OP_PIX       = 2'd2;

    typedef struct packed {
        logic [1:0]  op;
        logic [2:0]  test;
        logic [15:0] a;    // address, or pixel_x
        logic [15:0] d;    // write data, or pixel_y
        logic [15:0] exp;
    } entry_t;

    logic            clk;
    logic            arst_n;
    logic            wen;
    vid_pkg::addr_t  waddr;
    vid_pkg::word_t  wdata;
    vid_pkg::addr_t  raddr;
    vid_pkg::word_t  rdata;
    vid_pkg::coord_t pixel_x;
    vid_pkg::coord_t pixel_y;
    vid_pkg::pixel_t pixel;

    entry_t      table_q[$];
    logic [15:0] fb_m [`VID_FB_WORDS];   // framebuffer copy
    logic [15:0] pat_m [`VID_PAT_WORDS]; // pattern copy
    logic [1:0]  scale_m;
    logic [9:0]  hs_m;
    logic [9:0]  vs_m;
    logic [2:0]  cur_test;
    integer      seed;
    bit          table_ready;
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_name [NUM_TESTS];

    vid_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata),
        .raddr   (raddr),
        .rdata   (rdata),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .pixel   (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // reference model
    // ==================================================

    function automatic logic [15:0] mapped_word(input logic [15:0] a);
        if (a >= `VID_FB_START && a < `VID_FB_START + `VID_FB_WORDS) begin
            return fb_m[a - `VID_FB_START];
        end else if (a >= `VID_PAT_START && a < `VID_PAT_START + `VID_PAT_WORDS) begin
            return pat_m[a - `VID_PAT_START];
        end else if (a == `VID_SCALE_REG) begin
            return {14'h0, scale_m};
        end else if (a == `VID_HSCROLL_REG) begin
            return {6'h0, hs_m};
        end else if (a == `VID_VSCROLL_REG) begin
            return {6'h0, vs_m};
        end
        return 16'h0; // unmapped
    endfunction

    function automatic logic [11:0] pixel_colour(input logic [9:0] x, input logic [9:0] y);
        int          sx;
        int          sy;
        int          slot;
        int          tile;
        logic [15:0] w;
        sx   = ((int'(x) >> scale_m) + int'(hs_m)) % 1024;
        sy   = ((int'(y) >> scale_m) + int'(vs_m)) % 1024;
        slot = ((sy / 8) % 32) * `VID_MAP_COLS + (sx / 8) % 32;
        w    = fb_m[slot / 2];
        tile = (slot % 2 == 1) ? int'(w[15:8]) : int'(w[7:0]); // odd slot in high byte
        return pat_m[(tile % `VID_TILE_COUNT) * 64 + (sy % 8) * 8 + sx % 8][11:0];
    endfunction

    // ==================================================
    // table construction
    // ==================================================

    task automatic write_word(input logic [15:0] a, input logic [15:0] d);
        entry_t e;
        if (a >= `VID_FB_START && a < `VID_FB_START + `VID_FB_WORDS) begin
            fb_m[a - `VID_FB_START] = d;
        end else if (a >= `VID_PAT_START && a < `VID_PAT_START + `VID_PAT_WORDS) begin
            pat_m[a - `VID_PAT_START] = d;
        end else if (a == `VID_SCALE_REG) begin
            scale_m = d[1:0];
        end else if (a == `VID_HSCROLL_REG) begin
            hs_m = d[9:0];
        end else if (a == `VID_VSCROLL_REG) begin
            vs_m = d[9:0];
        end
        e = '{op: OP_WRITE, test: cur_test, a: a, d: d, exp: 16'h0};
        table_q.push_back(e);
    endtask

    task automatic read_back(input logic [15:0] a);
        entry_t e;
        e = '{op: OP_READ, test: cur_test, a: a, d: 16'h0, exp: mapped_word(a)};
        table_q.push_back(e);
    endtask

    task automatic sample_pixel(input logic [9:0] x, input logic [9:0] y);
        entry_t e;
        e = '{op: OP_PIX, test: cur_test, a: {6'h0, x}, d: {6'h0, y},
              exp: {4'h0, pixel_colour(x, y)}};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        test_name[0] = "reset_regs";
        test_name[1] = "memory_fill";
        test_name[2] = "bus_map";
        test_name[3] = "no_scroll";
        test_name[4] = "scrolled";
        test_name[5] = "scaled";
        scale_m  = '0;
        hs_m     = '0;
        vs_m     = '0;
        cur_test = 3'd0;
        read_back(`VID_SCALE_REG);
        read_back(`VID_HSCROLL_REG);
        read_back(`VID_VSCROLL_REG);

        cur_test = 3'd1;
        for (int i = 0; i < `VID_PAT_WORDS; i++) begin
            write_word(16'(`VID_PAT_START + i), 16'($random(seed)));
        end
        for (int i = 0; i < `VID_FB_WORDS; i++) begin
            write_word(16'(`VID_FB_START + i), 16'($random(seed))); // bytes above 15 too
        end
        for (int i = 0; i < `VID_PAT_WORDS; i += 61) begin
            read_back(16'(`VID_PAT_START + i));
        end
        for (int i = 0; i < `VID_FB_WORDS; i += 29) begin
            read_back(16'(`VID_FB_START + i));
        end

        cur_test = 3'd2;
        write_word(`VID_SCALE_REG, 16'hffff);
        write_word(`VID_HSCROLL_REG, 16'hfedc);
        write_word(`VID_VSCROLL_REG, 16'h0123);
        read_back(`VID_SCALE_REG);
        read_back(`VID_HSCROLL_REG);
        read_back(`VID_VSCROLL_REG);
        write_word(16'he1ff, 16'h5a3c); // last framebuffer word
        read_back(16'he1ff);
        write_word(16'hc3ff, 16'h0f1e); // last pattern word
        read_back(16'hc3ff);
        read_back(16'h0000);
        read_back(16'hbfff);
        read_back(16'hc400);
        read_back(16'hdfff);
        read_back(16'he200);
        read_back(16'hfffb);
        read_back(16'hffff);
        write_word(16'he200, 16'hdead); // just past each window
        write_word(16'hc400, 16'hbeef);
        write_word(16'hffff, 16'h0003);
        write_word(16'hfffb, 16'h0001);
        read_back(16'he000);
        read_back(16'hc000);
        read_back(16'he1ff);
        read_back(16'hc3ff);
        read_back(`VID_SCALE_REG);
        read_back(`VID_HSCROLL_REG);
        read_back(`VID_VSCROLL_REG);

        cur_test = 3'd3;
        write_word(`VID_SCALE_REG, 16'h0);
        write_word(`VID_HSCROLL_REG, 16'h0);
        write_word(`VID_VSCROLL_REG, 16'h0);
        for (int k = 0; k < 64; k++) begin
            sample_pixel(10'(k * 7), 10'((k * 13) % 480));
        end

        cur_test = 3'd4;
        write_word(`VID_HSCROLL_REG, 16'd300);
        write_word(`VID_VSCROLL_REG, 16'd1000);
        for (int k = 0; k < 48; k++) begin
            sample_pixel(10'((k * 19) % 640), 10'((k * 11) % 480));
        end
        write_word(`VID_HSCROLL_REG, 16'd1023);
        write_word(`VID_VSCROLL_REG, 16'd250);
        for (int k = 0; k < 48; k++) begin
            sample_pixel(10'((k * 29) % 640), 10'((k * 7) % 480));
        end

        cur_test = 3'd5;
        write_word(`VID_SCALE_REG, 16'd1);
        for (int k = 0; k < 48; k++) begin
            sample_pixel(10'((k * 23) % 640), 10'((k * 17) % 480));
        end
        write_word(`VID_SCALE_REG, 16'd3);
        for (int k = 0; k < 48; k++) begin
            sample_pixel(10'((k * 31) % 640), 10'((k * 19) % 480));
        end
    endtask

    // ==================================================
    // drive and check
    // ==================================================

    task automatic drive_entry(input entry_t e);
        wen <= 1'b0;
        case (e.op)
            OP_WRITE: begin
                wen   <= 1'b1;
                waddr <= e.a;
                wdata <= e.d;
            end
            OP_READ: begin
                raddr <= e.a;
            end
            default: begin
                pixel_x <= e.a[9:0];
                pixel_y <= e.d[9:0];
            end
        endcase
    endtask

    task automatic check_entry(input int idx);
        entry_t e;
        e = table_q[idx];
        if (e.op == OP_READ) begin
            checks[e.test]++;
            assert (rdata === e.exp) else begin
                $display("Error: rdata for raddr %h is %h, expected %h", e.a, rdata, e.exp);
                errors[e.test]++;
            end
        end else if (e.op == OP_PIX) begin
            checks[e.test]++;
            assert (pixel === e.exp[11:0]) else begin
                $display("Error: pixel for x %h y %h is %h, expected %h",
                         e.a[9:0], e.d[9:0], pixel, e.exp[11:0]);
                errors[e.test]++;
            end
        end
        if (idx == table_q.size() - 1 || table_q[idx + 1].test != e.test) begin
            $display("test %0d %s: %0d checks, %0d errors",
                     e.test, test_name[e.test], checks[e.test], errors[e.test]);
        end
    endtask

    initial begin
        int n;
        int total_checks;
        int total_errors;
        arst_n  = 1'b0;
        wen     = 1'b0;
        waddr   = '0;
        wdata   = '0;
        raddr   = '0;
        pixel_x = '0;
        pixel_y = '0;
        seed    = 32'ha14b_0f11;
        build_table();
        table_ready = 1'b1;
        n = table_q.size();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        checks[0] += 2;
        assert (pixel === 12'h0) else begin
            $display("Error: pixel during reset is %h, expected 000", pixel);
            errors[0]++;
        end
        assert (rdata === 16'h0) else begin
            $display("Error: rdata during reset is %h, expected 0000", rdata);
            errors[0]++;
        end
        @(posedge clk);
        arst_n <= 1'b1;

        // results of entry i appear at the negedge two entries later
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clk);
            if (i < n) begin
                drive_entry(table_q[i]);
            end else begin
                wen <= 1'b0;
            end
            @(negedge clk);
            if (i >= 2) begin
                check_entry(i - 2);
            end
        end

        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog, reset and pipeline drain fit in the 100 spare cycles
    initial begin
        wait (table_ready);
        #((table_q.size() + 100) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", table_q.size() + 100);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/vid_pkg.sv
logic/word_ram.sv
logic/bus_decoder.sv
logic/tile_renderer.sv
logic/vid_top.sv
dv/tb_vid_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the video memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module tb_vid_top \
    -o sim_tb_vid_top

./obj_dir/sim_tb_vid_top | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation did not pass, see sim.log"
    exit 1
fi
